//--- hdl/rv_isa_pkg.sv
// rv32i subset only: r/i alu ops, lw, sw, beq, bne; no jumps, no csr, no byte access
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    typedef enum logic [6:0] {
        op_r_type = 7'b0110011,
        op_i_type = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_nop = 4'd0,   // also the bubble encoding
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt
    } alu_op_e;

    // ------------------------------------------------------------
    // instruction word views
    // ------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [6:0] imm_hi;   // imm[11:5]
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;   // imm[4:0]
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        word_t     raw;
        r_fields_t r;   // r and i layout share these positions
        s_fields_t s;
    } instr_u;

    localparam word_t nop_instr = 32'h0000_0013;   // addi x0, x0, 0

endpackage

//--- hdl/rv_pipe_pkg.sv
// stage register layouts for the five-stage pipeline; bubbles are the all-zero value
package rv_pipe_pkg;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_ex,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    typedef struct packed {
        rv_isa_pkg::alu_op_e alu_op;
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        rv_isa_pkg::reg_addr_t rd;     // rs2 for a store
        rv_isa_pkg::word_t     bus1;
        rv_isa_pkg::word_t     bus2;   // rs2 value or immediate
        fwd_sel_e              fwd_a;
        fwd_sel_e              fwd_b;
    } id_ex_t;

    typedef struct packed {
        rv_isa_pkg::word_t     alu_out;
        rv_isa_pkg::reg_addr_t rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
    } ex_mem_t;

    typedef struct packed {
        rv_isa_pkg::word_t     wb_data;
        rv_isa_pkg::reg_addr_t rd;
        logic                  reg_write;
    } mem_wb_t;

endpackage

//--- hdl/instr_decoder.sv
// unknown opcodes decode as a bubble: no write, no memory access, alu_nop
`timescale 1ns/1ps

module instr_decoder (
    input  rv_isa_pkg::instr_u    instr,
    output rv_pipe_pkg::ctrl_t    ctrl,
    output logic                  is_beq,
    output logic                  is_bne,
    output logic                  uses_rs1,
    output logic                  uses_rs2,
    output rv_isa_pkg::reg_addr_t rs1,
    output rv_isa_pkg::reg_addr_t rs2,
    output rv_isa_pkg::reg_addr_t rd,
    output rv_isa_pkg::word_t     imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_r, is_i, is_load, is_store, is_branch;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;

    assign is_r      = (opcode == rv_isa_pkg::op_r_type);
    assign is_i      = (opcode == rv_isa_pkg::op_i_type);
    assign is_load   = (opcode == rv_isa_pkg::op_load);
    assign is_store  = (opcode == rv_isa_pkg::op_store);
    assign is_branch = (opcode == rv_isa_pkg::op_branch);

    assign is_beq   = is_branch && (funct3 == 3'b000);
    assign is_bne   = is_branch && (funct3 == 3'b001);
    assign uses_rs1 = is_r | is_i | is_load | is_store | is_branch;
    assign uses_rs2 = is_r | is_branch;   // store data is read later, in MEM

    // immediate generation
    always_comb begin
        if (is_branch) begin
            imm = {{20{instr.raw[31]}}, instr.raw[7], instr.raw[30:25], instr.raw[11:8], 1'b0};
        end else if (is_store) begin
            imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
        end else if (is_i && (funct3 == 3'b001 || funct3 == 3'b101)) begin
            imm = {27'd0, instr.r.rs2};   // shamt
        end else begin
            imm = {{20{instr.raw[31]}}, instr.raw[31:20]};
        end
    end

    always_comb begin
        ctrl           = '0;
        ctrl.reg_write = is_r | is_i | is_load;
        ctrl.mem_read  = is_load;
        ctrl.mem_write = is_store;
        if (is_r || is_i) begin
            case (funct3)
                3'b000:  ctrl.alu_op = (is_r && instr.r.funct7[5]) ? rv_isa_pkg::alu_sub
                                                                   : rv_isa_pkg::alu_add;
                3'b001:  ctrl.alu_op = rv_isa_pkg::alu_sll;
                3'b010:  ctrl.alu_op = rv_isa_pkg::alu_slt;
                3'b100:  ctrl.alu_op = rv_isa_pkg::alu_xor;
                3'b101:  ctrl.alu_op = instr.r.funct7[5] ? rv_isa_pkg::alu_sra
                                                         : rv_isa_pkg::alu_srl;
                3'b110:  ctrl.alu_op = rv_isa_pkg::alu_or;
                3'b111:  ctrl.alu_op = rv_isa_pkg::alu_and;
                default: ctrl.alu_op = rv_isa_pkg::alu_nop;
            endcase
        end else if (is_load || is_store) begin
            ctrl.alu_op = rv_isa_pkg::alu_add;   // address = rs1 + imm
        end
    end

endmodule

//--- hdl/hazard_unit.sv
// assumes a load is the only producer whose result is late; x0 never forwards
`timescale 1ns/1ps

module hazard_unit (
    input  rv_isa_pkg::reg_addr_t rs1,
    input  rv_isa_pkg::reg_addr_t rs2,
    input  logic                  uses_rs1,
    input  logic                  uses_rs2,
    input  rv_pipe_pkg::id_ex_t   ex_stage,
    input  rv_pipe_pkg::ex_mem_t  mem_stage,
    output logic                  load_use,
    output rv_pipe_pkg::fwd_sel_e fwd_id_a,
    output rv_pipe_pkg::fwd_sel_e fwd_id_b,
    output rv_pipe_pkg::fwd_sel_e fwd_ex_a,
    output rv_pipe_pkg::fwd_sel_e fwd_ex_b
);

    logic       ex_writes, mem_writes;
    logic [1:0] ex_hit, mem_hit;   // bit 0 rs1, bit 1 rs2

    assign ex_writes  = ex_stage.ctrl.reg_write && (ex_stage.rd != '0);
    assign mem_writes = mem_stage.reg_write && (mem_stage.rd != '0);

    assign ex_hit  = {ex_writes && uses_rs2 && (ex_stage.rd == rs2),
                      ex_writes && uses_rs1 && (ex_stage.rd == rs1)};
    assign mem_hit = {mem_writes && uses_rs2 && (mem_stage.rd == rs2),
                      mem_writes && uses_rs1 && (mem_stage.rd == rs1)};

    // covers branches too, since they compare in decode
    assign load_use = ex_stage.ctrl.mem_read && (|ex_hit);

    // decode side: EX result, then MEM result, then register file
    function automatic rv_pipe_pkg::fwd_sel_e id_sel(logic ex_h, logic mem_h, logic ex_load);
        if (ex_h && !ex_load) return rv_pipe_pkg::fwd_ex;
        if (mem_h)            return rv_pipe_pkg::fwd_mem;
        return rv_pipe_pkg::fwd_none;
    endfunction

    // execute side: producers will have moved one stage on
    function automatic rv_pipe_pkg::fwd_sel_e ex_sel(logic ex_h, logic mem_h);
        if (ex_h)  return rv_pipe_pkg::fwd_mem;
        if (mem_h) return rv_pipe_pkg::fwd_wb;
        return rv_pipe_pkg::fwd_none;
    endfunction

    assign fwd_id_a = id_sel(ex_hit[0], mem_hit[0], ex_stage.ctrl.mem_read);
    assign fwd_id_b = id_sel(ex_hit[1], mem_hit[1], ex_stage.ctrl.mem_read);
    assign fwd_ex_a = ex_sel(ex_hit[0], mem_hit[0]);
    assign fwd_ex_b = ex_sel(ex_hit[1], mem_hit[1]);

endmodule

//--- hdl/reg_file.sv
// three combinational read ports with write-back bypass; x0 reads as zero
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_pipe_pkg::mem_wb_t  wb,
    input  rv_isa_pkg::reg_addr_t ra,
    input  rv_isa_pkg::reg_addr_t rb,
    input  rv_isa_pkg::reg_addr_t rc,
    output rv_isa_pkg::word_t     rdata_a,
    output rv_isa_pkg::word_t     rdata_b,
    output rv_isa_pkg::word_t     rdata_c
);

    rv_isa_pkg::word_t     regs [32];
    rv_isa_pkg::reg_addr_t addr [3];
    rv_isa_pkg::word_t     data [3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.wb_data;
        end
    end

    assign addr = '{ra, rb, rc};

    always_comb begin
        for (int p = 0; p < 3; p++) begin
            if (addr[p] == '0) begin
                data[p] = '0;
            end else if (wb.reg_write && wb.rd == addr[p]) begin
                data[p] = wb.wb_data;   // same-cycle bypass
            end else begin
                data[p] = regs[addr[p]];
            end
        end
    end

    assign rdata_a = data[0];
    assign rdata_b = data[1];
    assign rdata_c = data[2];

endmodule

//--- hdl/execute_unit.sv
// shifts use the low 5 bits of operand b; slt and sra treat operands as signed
`timescale 1ns/1ps

module execute_unit (
    input  rv_pipe_pkg::id_ex_t ex_stage,
    input  rv_isa_pkg::word_t   mem_alu_out,
    input  rv_isa_pkg::word_t   wb_data,
    output rv_isa_pkg::word_t   alu_out
);

    rv_isa_pkg::word_t op_a, op_b;

    function automatic rv_isa_pkg::word_t pick(rv_pipe_pkg::fwd_sel_e sel,
                                               rv_isa_pkg::word_t bus,
                                               rv_isa_pkg::word_t mem,
                                               rv_isa_pkg::word_t wb);
        case (sel)
            rv_pipe_pkg::fwd_mem: return mem;
            rv_pipe_pkg::fwd_wb:  return wb;
            default:              return bus;
        endcase
    endfunction

    assign op_a = pick(ex_stage.fwd_a, ex_stage.bus1, mem_alu_out, wb_data);
    assign op_b = pick(ex_stage.fwd_b, ex_stage.bus2, mem_alu_out, wb_data);

    // ------------------------------------------------------------
    // alu
    // ------------------------------------------------------------
    always_comb begin
        case (ex_stage.ctrl.alu_op)
            rv_isa_pkg::alu_add: alu_out = op_a + op_b;
            rv_isa_pkg::alu_sub: alu_out = op_a - op_b;
            rv_isa_pkg::alu_and: alu_out = op_a & op_b;
            rv_isa_pkg::alu_or:  alu_out = op_a | op_b;
            rv_isa_pkg::alu_xor: alu_out = op_a ^ op_b;
            rv_isa_pkg::alu_sll: alu_out = op_a << op_b[4:0];
            rv_isa_pkg::alu_srl: alu_out = op_a >> op_b[4:0];
            rv_isa_pkg::alu_sra: alu_out = $signed(op_a) >>> op_b[4:0];
            rv_isa_pkg::alu_slt: alu_out = rv_isa_pkg::word_t'($signed(op_a) < $signed(op_b));
            default:             alu_out = '0;   // bubble
        endcase
    end

endmodule

//--- hdl/rv_pipeline.sv
// fetch read data must be valid in the cycle of the address; both ports are big-endian words
`timescale 1ns/1ps

module rv_pipeline #(
    parameter logic [29:0] reset_pc = 30'd0
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [29:0] icache_addr,
    input  logic [31:0] icache_rdata,
    output logic        dcache_ren,
    output logic        dcache_wen,
    output logic [29:0] dcache_addr,
    output logic [31:0] dcache_wdata,
    input  logic [31:0] dcache_rdata,
    input  logic        dcache_stall
);

    logic [29:0]                pc, id_pc;
    rv_isa_pkg::instr_u         id_instr;
    rv_pipe_pkg::ctrl_t         id_ctrl;
    logic                       id_beq, id_bne, id_uses_rs1, id_uses_rs2;
    rv_isa_pkg::reg_addr_t      id_rs1, id_rs2, id_rd;
    rv_isa_pkg::word_t          id_imm, id_opa, id_opb, rf_a, rf_b, rf_c;
    logic                       load_use, branch_taken;
    rv_pipe_pkg::fwd_sel_e      fwd_id_a, fwd_id_b, fwd_ex_a, fwd_ex_b;
    rv_pipe_pkg::id_ex_t        id_ex;
    rv_pipe_pkg::ex_mem_t       ex_mem;
    rv_pipe_pkg::mem_wb_t       mem_wb;
    rv_isa_pkg::word_t          ex_alu_out, mem_result, pc_sum;

    // ------------------------------------------------------------
    // fetch
    // ------------------------------------------------------------
    assign icache_addr = pc;

    // single adder: sequential fetch or branch target
    assign pc_sum = branch_taken ? {id_pc, 2'b00} + id_imm : {pc, 2'b00} + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= reset_pc;
            id_instr.raw <= rv_isa_pkg::nop_instr;
            id_pc        <= '0;
        end else if (!dcache_stall && !load_use) begin
            pc    <= pc_sum[31:2];
            id_pc <= pc;
            if (branch_taken) begin
                id_instr.raw <= rv_isa_pkg::nop_instr;   // flush the wrong-path fetch
            end else begin
                id_instr.raw <= {<<8{icache_rdata}};
            end
        end
    end

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    instr_decoder u_decoder (
        .instr(id_instr), .ctrl(id_ctrl), .is_beq(id_beq), .is_bne(id_bne),
        .uses_rs1(id_uses_rs1), .uses_rs2(id_uses_rs2),
        .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm)
    );

    hazard_unit u_hazard (
        .rs1(id_rs1), .rs2(id_rs2), .uses_rs1(id_uses_rs1), .uses_rs2(id_uses_rs2),
        .ex_stage(id_ex), .mem_stage(ex_mem), .load_use(load_use),
        .fwd_id_a(fwd_id_a), .fwd_id_b(fwd_id_b), .fwd_ex_a(fwd_ex_a), .fwd_ex_b(fwd_ex_b)
    );

    reg_file u_regs (
        .clk(clk), .rst_n(rst_n), .wb(mem_wb),
        .ra(id_rs1), .rb(id_rs2), .rc(ex_mem.rd),   // port c feeds store data
        .rdata_a(rf_a), .rdata_b(rf_b), .rdata_c(rf_c)
    );

    function automatic rv_isa_pkg::word_t id_operand(rv_pipe_pkg::fwd_sel_e sel,
                                                     rv_isa_pkg::word_t rf,
                                                     rv_isa_pkg::word_t ex,
                                                     rv_isa_pkg::word_t mem);
        case (sel)
            rv_pipe_pkg::fwd_ex:  return ex;
            rv_pipe_pkg::fwd_mem: return mem;
            default:              return rf;
        endcase
    endfunction

    assign id_opa = id_operand(fwd_id_a, rf_a, ex_alu_out, mem_result);
    assign id_opb = id_operand(fwd_id_b, rf_b, ex_alu_out, mem_result);

    // compare is meaningless while a load result is still outstanding
    assign branch_taken = !load_use && ((id_beq && id_opa == id_opb) ||
                                        (id_bne && id_opa != id_opb));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (dcache_stall) begin
            // WB moves on during the stall, so capture a WB operand before it leaves
            if (id_ex.fwd_a == rv_pipe_pkg::fwd_wb) begin
                id_ex.bus1  <= mem_wb.wb_data;
                id_ex.fwd_a <= rv_pipe_pkg::fwd_none;
            end
            if (id_ex.fwd_b == rv_pipe_pkg::fwd_wb) begin
                id_ex.bus2  <= mem_wb.wb_data;
                id_ex.fwd_b <= rv_pipe_pkg::fwd_none;
            end
        end else if (load_use) begin
            id_ex <= '0;   // bubble
        end else begin
            id_ex <= '{ctrl: id_ctrl, rd: id_ctrl.mem_write ? id_rs2 : id_rd,
                       bus1: id_opa, bus2: id_uses_rs2 ? id_opb : id_imm,
                       fwd_a: fwd_ex_a, fwd_b: fwd_ex_b};
        end
    end

    // ------------------------------------------------------------
    // execute, memory, write-back
    // ------------------------------------------------------------
    execute_unit u_execute (
        .ex_stage(id_ex), .mem_alu_out(ex_mem.alu_out), .wb_data(mem_wb.wb_data),
        .alu_out(ex_alu_out)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!dcache_stall) begin
            ex_mem <= '{alu_out: ex_alu_out, rd: id_ex.rd, reg_write: id_ex.ctrl.reg_write,
                        mem_read: id_ex.ctrl.mem_read, mem_write: id_ex.ctrl.mem_write};
        end
    end

    assign dcache_ren   = ex_mem.mem_read;
    assign dcache_wen   = ex_mem.mem_write;
    assign dcache_addr  = ex_mem.alu_out[31:2];
    assign dcache_wdata = {<<8{rf_c}};
    assign mem_result   = ex_mem.mem_read ? {<<8{dcache_rdata}} : ex_mem.alu_out;

    // keeps advancing under dcache_stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{wb_data: mem_result, rd: ex_mem.rd, reg_write: ex_mem.reg_write};
        end
    end

endmodule

//--- include/tb_program.svh
// words in register byte order, program at word 0; fetch past prog_len must return nop
`ifndef tb_program_svh
`define tb_program_svh

localparam int prog_len = 32;

localparam logic [31:0] prog_image [prog_len] = '{
    32'h0070_0213,   // addi x4, x0, 7
    32'h0400_2083,   // lw   x1, 0x40(x0)    -16
    32'h0010_8133,   // add  x2, x1, x1      load-use
    32'h0820_2023,   // sw   x2, 0x80(x0)
    32'h0440_2183,   // lw   x3, 0x44(x0)    7
    32'h0041_8463,   // beq  x3, x4, +8      load-use branch, taken
    32'h0800_2223,   // sw   x0, 0x84(x0)    must never store
    32'h4040_82B3,   // sub  x5, x1, x4
    32'h0040_A333,   // slt  x6, x1, x4
    32'h0850_2223,   // sw   x5, 0x84(x0)
    32'h0860_2423,   // sw   x6, 0x88(x0)
    32'h4020_D393,   // srai x7, x1, 2
    32'h01C0_D413,   // srli x8, x1, 28
    32'h0042_1493,   // slli x9, x4, 4
    32'h0083_C533,   // xor  x10, x7, x8
    32'h0095_05B3,   // add  x11, x10, x9    back to back
    32'h08B0_2623,   // sw   x11, 0x8c(x0)
    32'hFF10_A613,   // slti x12, x1, -15
    32'h0556_4693,   // xori x13, x12, 0x55
    32'h1006_E713,   // ori  x14, x13, 0x100
    32'h1F07_7793,   // andi x15, x14, 0x1f0
    32'h0007_9463,   // bne  x15, x0, +8     taken, operand from EX
    32'h0800_2A23,   // sw   x0, 0x94(x0)    must never store
    32'h08F0_2823,   // sw   x15, 0x90(x0)
    32'h00D6_0463,   // beq  x12, x13, +8    not taken
    32'h08D0_2A23,   // sw   x13, 0x94(x0)
    32'h0095_F833,   // and  x16, x11, x9
    32'h0092_E8B3,   // or   x17, x5, x9
    32'h00C3_1463,   // bne  x6, x12, +8     not taken
    32'h0900_2C23,   // sw   x16, 0x98(x0)
    32'h0910_2E23,   // sw   x17, 0x9c(x0)
    32'h0EE0_2E23    // sw   x14, 0xfc(x0)   end marker
};

// data memory preload, word addressed
localparam int          dmem_init_base = 16;   // byte address 0x40
localparam logic [31:0] dmem_init [2]  = '{32'hFFFF_FFF0, 32'h0000_0007};

localparam logic [31:0] marker_addr = 32'h0000_00FC;

`endif

//--- testbench/tb_rv_pipeline.sv
// program and data preload come from tb_program.svh; data memory covers byte addresses 0x00-0xff
`timescale 1ns/1ps

module tb_rv_pipeline;

    `include "tb_program.svh"

    localparam logic [29:0] start_word = 30'd0;
    localparam int          max_cycles = prog_len * 8 + 100;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_rec_t;

    logic        clk, rst_n, dcache_ren, dcache_wen, dcache_stall, run_done;
    logic [29:0] icache_addr, dcache_addr;
    logic [31:0] icache_rdata, dcache_wdata, dcache_rdata, lcg_state;
    logic [31:0] dmem [64];                       // memory byte order
    logic [31:0] iss_regs [32];
    logic [31:0] iss_mem [64];                    // register byte order
    logic        iss_done;
    store_rec_t  exp_q [$];
    store_rec_t  got_rec;

    rv_pipeline #(.reset_pc(start_word)) DUT (
        .clk(clk), .rst_n(rst_n), .icache_addr(icache_addr), .icache_rdata(icache_rdata),
        .dcache_ren(dcache_ren), .dcache_wen(dcache_wen), .dcache_addr(dcache_addr),
        .dcache_wdata(dcache_wdata), .dcache_rdata(dcache_rdata), .dcache_stall(dcache_stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h5A5A_0000 ^ (idx * 32'h0001_0003);   // unique per word
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] program_word(input logic [29:0] a);
        if (a < prog_len) begin
            return prog_image[a];
        end
        return 32'h0000_0013;   // addi x0, x0, 0
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // memories and stall source
    // ------------------------------------------------------------
    assign icache_rdata = swap_bytes(program_word(icache_addr));

    // read data only during an unstalled read
    assign dcache_rdata = (dcache_ren && !dcache_stall) ? dmem[dcache_addr[5:0]]
                                                        : 32'hDEAD_BEEF;

    always @(posedge clk) begin
        if (rst_n && dcache_wen && !dcache_stall) begin
            dmem[dcache_addr[5:0]] <= dcache_wdata;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            dcache_stall <= 1'b0;
        end else begin
            lcg_state = lcg_next(lcg_state);
            dcache_stall <= (lcg_state[17:16] == 2'b00);   // about one in four
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            3'd7: return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // one instruction on the model state, returns the next byte pc
    function automatic logic [31:0] iss_step(input logic [31:0] pc);
        logic [31:0] w, a, b, imm_i, imm_s, imm_b, res, addr, next_pc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        store_rec_t  rec;
        w       = program_word(pc[31:2]);
        rd      = w[11:7];
        f3      = w[14:12];
        a       = iss_regs[w[19:15]];
        b       = iss_regs[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        next_pc = pc + 32'd4;
        case (w[6:0])
            7'b0110011: res = alu_ref(f3, w[30], a, b);
            7'b0010011: res = alu_ref(f3, (f3 == 3'd5) && w[30], a,
                                      (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, w[24:20]} : imm_i);
            7'b0000011: begin
                addr = a + imm_i;
                res  = iss_mem[addr[7:2]];
            end
            7'b0100011: begin
                addr = a + imm_s;
                iss_mem[addr[7:2]] = b;
                rec.addr = addr;
                rec.data = b;
                exp_q.push_back(rec);
                iss_done = (addr == marker_addr);
            end
            7'b1100011: begin
                if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                    next_pc = pc + imm_b;
                end
            end
            default: ;
        endcase
        if (rd != 5'd0 && (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011 ||
                           w[6:0] == 7'b0000011)) begin
            iss_regs[rd] = res;
        end
        return next_pc;
    endfunction

    task automatic build_expected();
        logic [31:0] pc;
        int          steps;
        for (int i = 0; i < 64; i++) begin
            iss_mem[i] = fill_word(i);
        end
        foreach (dmem_init[k]) begin
            iss_mem[dmem_init_base + k] = dmem_init[k];
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= swap_bytes(iss_mem[i]);   // DUT memory holds the swapped image
            iss_regs[i % 32] = 32'd0;
        end
        pc       = {start_word, 2'b00};
        steps    = 0;
        iss_done = 1'b0;
        while (!iss_done && steps < prog_len * 4) begin
            pc = iss_step(pc);
            steps++;
        end
        if (!iss_done) begin
            stop_with_failure("reference model never reached the end marker store");
        end
    endtask

    // ------------------------------------------------------------
    // store compare, watchdog, main sequence
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && dcache_wen && !dcache_stall) begin
            if (exp_q.size() == 0) begin
                stop_with_failure($sformatf("unexpected store to %h at %0t",
                                            {dcache_addr, 2'b00}, $time));
            end else begin
                got_rec = exp_q.pop_front();
                check_value("dcache_addr", {dcache_addr, 2'b00}, got_rec.addr);
                check_value("dcache_wdata", swap_bytes(dcache_wdata), got_rec.data);
                if (got_rec.addr == marker_addr) begin
                    run_done = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (max_cycles) @(posedge clk);
        stop_with_failure($sformatf("timeout after %0d cycles without the marker store",
                                    max_cycles));
    end

    initial begin
        rst_n        <= 1'b0;
        dcache_stall <= 1'b0;
        lcg_state    = 32'd77487;
        run_done     = 1'b0;
        build_expected();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("icache_addr", icache_addr, start_word);
        repeat (3) begin   // pipeline still full of bubbles
            check_value("dcache_ren", dcache_ren, 1'b0);
            check_value("dcache_wen", dcache_wen, 1'b0);
            @(negedge clk);
        end
        wait (run_done);
        repeat (10) @(posedge clk);   // any late store shows up as unexpected
        if (exp_q.size() != 0) begin
            stop_with_failure($sformatf("%0d expected stores never appeared", exp_q.size()));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/instr_decoder.sv
hdl/hazard_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/rv_pipeline.sv
testbench/tb_rv_pipeline.sv

//--- Bender.yml
package:
  name: rv_pipeline

sources:
  - files:
      - hdl/rv_isa_pkg.sv
      - hdl/rv_pipe_pkg.sv
      - hdl/instr_decoder.sv
      - hdl/hazard_unit.sv
      - hdl/reg_file.sv
      - hdl/execute_unit.sv
      - hdl/rv_pipeline.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_rv_pipeline.sv
